//--- tb.f
+incdir+verif
hw/rvc_isa_pkg.sv
hw/rvc_pipe_pkg.sv
hw/rvc_fetch_aligner.sv
hw/rvc_lane.sv
hw/rvc_issue_packer.sv
hw/rvc_expand_top.sv
verif/tb_rvc_expand.sv

//--- verif/rvc_ref_encode.svh
/*
 * Reference encoders for the expander testbench
 * Base-format instruction encoders, plus a builder that returns a
 * compressed parcel with the lane result it must expand to
 */

`ifndef RVC_REF_ENCODE_SVH
`define RVC_REF_ENCODE_SVH

// Compressed forms the builder knows
typedef enum int {
  CF_ADDI4SPN, CF_LW, CF_SW, CF_NOP, CF_ADDI, CF_JAL, CF_LI, CF_ADDI16SP, CF_LUI,
  CF_SRLI, CF_SRAI, CF_ANDI, CF_SUB, CF_XOR, CF_OR, CF_AND, CF_J, CF_BEQZ, CF_BNEZ,
  CF_SLLI, CF_LWSP, CF_JR, CF_MV, CF_EBREAK, CF_JALR, CF_ADD, CF_SWSP, CF_COUNT
} c_form_e;

// Parcel and the lane result expected for it
typedef struct packed {
  parcel_t   p;
  lane_out_t res;  // Only used when p is a compressed parcel
} ref_parcel_t;

// ==================================================
// Base formats
// ==================================================
function automatic instr_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                 input logic [2:0] f3, input reg_idx_t rd,
                                 input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic instr_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                 input reg_idx_t rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

function automatic instr_t enc_b(input logic [12:0] imm, input reg_idx_t rs1,
                                 input logic [2:0] f3);
  return {imm[12], imm[10:5], REG_ZERO, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};  // rs2 = x0
endfunction

function automatic instr_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

function automatic instr_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                 input reg_idx_t rs1, input logic [2:0] f3,
                                 input reg_idx_t rd);
  return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

// ==================================================
// Compressed builder
// ==================================================
// rd/rs2 feed the register fields, r the immediates; fields a form
// needs nonzero are bumped so the result stays legal
function automatic ref_parcel_t build_c(input c_form_e form, input reg_idx_t rd,
                                        input reg_idx_t rs2, input logic [31:0] r);
  ref_parcel_t rp;
  parcel_t     p;
  instr_t      e;
  reg_idx_t    xd;   // rd' as x8..x15
  reg_idx_t    xs;   // rs2' as x8..x15
  reg_idx_t    nz;   // rd, never x0
  reg_idx_t    ns;   // rs2, never x0
  reg_idx_t    lr;   // LUI rd, not x2
  logic [9:0]  u10;
  logic [7:0]  u8;
  logic [6:0]  u7;
  logic [5:0]  i6;
  logic [11:0] s12;  // i6 sign-extended
  logic [11:0] o12;  // Jump offset
  logic [8:0]  o9;   // Branch offset
  logic [9:0]  n10;  // ADDI16SP / LUI immediate source
  logic [1:0]  f2;
  logic [2:0]  f3;
  xd  = {2'b01, rd[2:0]};
  xs  = {2'b01, rs2[2:0]};
  nz  = (rd == REG_ZERO) ? REG_RA : rd;
  ns  = (rs2 == REG_ZERO) ? REG_RA : rs2;
  lr  = (rd == REG_SP) ? 5'd3 : rd;
  u10 = {r[7:0], 2'b00};
  if (u10 == '0) u10 = 10'd4;
  u8  = {r[5:0], 2'b00};
  u7  = {r[4:0], 2'b00};
  i6  = r[5:0];
  s12 = {{6{i6[5]}}, i6};
  o12 = {r[10:0], 1'b0};
  o9  = {r[7:0], 1'b0};
  n10 = {r[11:6], 4'b0000};
  if (n10 == '0) n10 = 10'h010;
  f2  = 2'(form - CF_SUB);
  f3  = (f2 == 2'd0) ? F3_ADD : (f2 == 2'd1) ? F3_XOR : (f2 == 2'd2) ? F3_OR : F3_AND;

  case (form)
    CF_ADDI4SPN: begin
      p = {3'b000, u10[5:4], u10[9:6], u10[2], u10[3], rd[2:0], 2'b00};
      e = enc_i({2'b00, u10}, REG_SP, F3_ADD, xd, OPC_OP_IMM);
    end
    CF_LW: begin  // rs2 field gives the base register
      p = {3'b010, u7[5:3], rs2[2:0], u7[2], u7[6], rd[2:0], 2'b00};
      e = enc_i({5'b0, u7}, xs, F3_LW, xd, OPC_LOAD);
    end
    CF_SW: begin
      p = {3'b110, u7[5:3], rd[2:0], u7[2], u7[6], rs2[2:0], 2'b00};
      e = enc_s({5'b0, u7}, xs, xd, F3_SW);
    end
    CF_ADDI: begin
      p = {3'b000, i6[5], nz, i6[4:0], 2'b01};
      e = enc_i(s12, nz, F3_ADD, nz, OPC_OP_IMM);
    end
    CF_JAL, CF_J: begin
      p = {(form == CF_JAL) ? 3'b001 : 3'b101, o12[11], o12[4], o12[9:8], o12[10],
           o12[6], o12[7], o12[3:1], o12[5], 2'b01};
      e = enc_j({{9{o12[11]}}, o12}, (form == CF_JAL) ? REG_RA : REG_ZERO);
    end
    CF_LI: begin  // rd 0 is a hint
      p = {3'b010, i6[5], rd, i6[4:0], 2'b01};
      e = enc_i(s12, REG_ZERO, F3_ADD, rd, OPC_OP_IMM);
    end
    CF_ADDI16SP: begin
      p = {3'b011, n10[9], REG_SP, n10[4], n10[6], n10[8:7], n10[5], 2'b01};
      e = enc_i({{2{n10[9]}}, n10}, REG_SP, F3_ADD, REG_SP, OPC_OP_IMM);
    end
    CF_LUI: begin  // rd 0 is a hint
      p = {3'b011, n10[9], lr, n10[8:4], 2'b01};
      e = {{14{n10[9]}}, n10[9:4], lr, OPC_LUI};
    end
    CF_SRLI, CF_SRAI: begin
      p = {3'b100, 1'b0, (form == CF_SRAI) ? 2'b01 : 2'b00, rd[2:0], i6[4:0], 2'b01};
      e = enc_i({(form == CF_SRAI) ? 7'b0100000 : 7'b0000000, i6[4:0]}, xd, F3_SR, xd,
                OPC_OP_IMM);
    end
    CF_ANDI: begin
      p = {3'b100, i6[5], 2'b10, rd[2:0], i6[4:0], 2'b01};
      e = enc_i(s12, xd, F3_AND, xd, OPC_OP_IMM);
    end
    CF_SUB, CF_XOR, CF_OR, CF_AND: begin
      p = {3'b100, 1'b0, 2'b11, rd[2:0], f2, rs2[2:0], 2'b01};
      e = enc_r((form == CF_SUB) ? 7'b0100000 : 7'b0, xs, xd, f3, xd);
    end
    CF_BEQZ, CF_BNEZ: begin
      p = {(form == CF_BEQZ) ? 3'b110 : 3'b111, o9[8], o9[4:3], rd[2:0], o9[7:6],
           o9[2:1], o9[5], 2'b01};
      e = enc_b({{4{o9[8]}}, o9}, xd, (form == CF_BEQZ) ? F3_BEQ : F3_BNE);
    end
    CF_SLLI: begin  // rd 0 is a hint
      p = {3'b000, 1'b0, rd, i6[4:0], 2'b10};
      e = enc_i({7'b0, i6[4:0]}, rd, F3_SLL, rd, OPC_OP_IMM);
    end
    CF_LWSP: begin
      p = {3'b010, u8[5], nz, u8[4:2], u8[7:6], 2'b10};
      e = enc_i({4'b0, u8}, REG_SP, F3_LW, nz, OPC_LOAD);
    end
    CF_JR, CF_JALR: begin
      p = {3'b100, form == CF_JALR, nz, 5'b0, 2'b10};
      e = enc_i(12'b0, nz, F3_ADD, (form == CF_JALR) ? REG_RA : REG_ZERO, OPC_JALR);
    end
    CF_MV, CF_ADD: begin  // rd 0 is a hint
      p = {3'b100, form == CF_ADD, rd, ns, 2'b10};
      e = enc_r(7'b0, ns, (form == CF_ADD) ? rd : REG_ZERO, F3_ADD, rd);
    end
    CF_EBREAK: begin
      p = 16'h9002;
      e = INSTR_EBREAK;
    end
    CF_SWSP: begin
      p = {3'b110, u8[5:2], u8[7:6], rs2, 2'b10};
      e = enc_s({4'b0, u8}, rs2, REG_SP, F3_SW);
    end
    default: begin  // C.NOP
      p = 16'h0001;
      e = INSTR_NOP;
    end
  endcase

  rp.p   = p;
  rp.res = '{valid: 1'b1, instr: e, illegal: 1'b0, is_c: 1'b1};
  return rp;
endfunction

// Reserved encoding, flagged and replaced by a NOP
function automatic ref_parcel_t illegal_c(input parcel_t p);
  ref_parcel_t rp;
  rp.p   = p;
  rp.res = '{valid: 1'b1, instr: INSTR_NOP, illegal: 1'b1, is_c: 1'b1};
  return rp;
endfunction

// Half of a 32-bit instruction, no result of its own
function automatic ref_parcel_t raw_parcel(input parcel_t p);
  ref_parcel_t rp;
  rp.p   = p;
  rp.res = '0;
  return rp;
endfunction

`endif

//--- verif/tb_rvc_expand.sv
/*
 * Testbench for the RV32C expander
 * Directed tests push fetch words, a model of the aligner predicts
 * each word's packed result, and a monitor collects out_valid results
 */

module tb_rvc_expand;

  import rvc_isa_pkg::*;
  import rvc_pipe_pkg::*;

  `include "rvc_ref_encode.svh"

  localparam int NUM_LANES  = 2;
  localparam int CNT_W      = $clog2(NUM_LANES + 1);
  localparam int MAX_CYCLES = 2000;  // About ten times the test length

  // One out_valid result
  typedef struct packed {
    int                        cyc;    // Cycle the result is due or was seen
    logic [CNT_W-1:0]          count;
    lane_out_t [NUM_LANES-1:0] slots;
  } out_rec_t;

  logic                      clk;
  logic                      rst_n;
  logic                      fetch_valid;
  parcel_t [NUM_LANES-1:0]   fetch_word;
  logic                      out_valid;
  lane_out_t [NUM_LANES-1:0] out_slots;
  logic [CNT_W-1:0]          out_count;

  out_rec_t    exp_q[$];  // Predicted, in fetch order
  out_rec_t    got_q[$];  // Seen on the outputs
  out_rec_t    mon_rec;
  logic        held;      // Model of the aligner's held lower half
  parcel_t     held_lo;
  int          cycles;
  ref_parcel_t nop;

  rvc_expand_top #(.NUM_LANES(NUM_LANES)) u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .fetch_word  (fetch_word),
    .out_valid   (out_valid),
    .out_slots   (out_slots),
    .out_count   (out_count)
  );

  // ==================================================
  // Clock, timeout, monitor
  // ==================================================
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("TIMEOUT: run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $fatal(1);
    end
  end

  always @(negedge clk) begin  // Outputs settled mid-cycle
    if (rst_n && out_valid) begin
      mon_rec.cyc   = cycles;
      mon_rec.count = out_count;
      mon_rec.slots = out_slots;
      got_q.push_back(mon_rec);
    end
  end

  // ==================================================
  // Helpers
  // ==================================================
  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      fetch_valid = 1'b0;
    end
  endtask

  // Drive one word and predict its result by the boundary rules
  task automatic send_word(input ref_parcel_t w0, input ref_parcel_t w1);
    ref_parcel_t w[NUM_LANES];
    out_rec_t    rec;
    int          n;
    logic        skip;
    w[0] = w0;
    w[1] = w1;
    rec  = '0;
    n    = 0;
    skip = 1'b0;
    if (held) begin  // Close the straddle
      rec.slots[0] = '{valid: 1'b1, instr: {w[0].p, held_lo}, illegal: 1'b0, is_c: 1'b0};
      n    = 1;
      skip = 1'b1;
    end
    held = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (skip) begin
        skip = 1'b0;
      end else if (w[i].p[1:0] != QUAD_FULL) begin
        rec.slots[n] = w[i].res;
        n++;
      end else if (i < NUM_LANES - 1) begin
        rec.slots[n] = '{valid: 1'b1, instr: {w[i + 1].p, w[i].p}, illegal: 1'b0,
                         is_c: 1'b0};
        n++;
        skip = 1'b1;
      end else begin
        held    = 1'b1;  // Lower half waits for the next word
        held_lo = w[i].p;
      end
    end
    rec.count = CNT_W'(n);
    @(posedge clk);
    #1;
    fetch_valid = 1'b1;
    fetch_word  = {w[1].p, w[0].p};
    rec.cyc     = cycles + 3;  // Aligner, lane and packer stages
    exp_q.push_back(rec);
  endtask

  // Stop fetching, then match every predicted result in order
  task automatic check_results(input string name);
    out_rec_t exp;
    out_rec_t got;
    idle_cycles(1);
    while (exp_q.size() > 0) begin
      exp = exp_q.pop_front();
      while (got_q.size() == 0) @(negedge clk);
      got = got_q.pop_front();
      check_eq({name, " latency"}, exp.cyc, got.cyc);
      check_eq({name, " count"}, exp.count, got.count);
      for (int i = 0; i < NUM_LANES; i++) begin
        check_eq($sformatf("%s slot %0d", name, i), exp.slots[i], got.slots[i]);
      end
    end
  endtask

  function automatic ref_parcel_t random_c();
    return build_c(c_form_e'($urandom % CF_COUNT), reg_idx_t'($urandom),
                   reg_idx_t'($urandom), $urandom);
  endfunction

  // ==================================================
  // Tests
  // ==================================================
  task automatic test_reset_idle();
    repeat (10) begin
      @(negedge clk);
      check_eq("reset_idle out_valid", 1'b0, out_valid);
    end
  endtask

  task automatic test_legal();
    c_form_e hints[$];
    hints = '{CF_LI, CF_LUI, CF_SLLI, CF_MV, CF_ADD};
    for (int f = 0; f < CF_COUNT; f++) begin
      send_word(build_c(c_form_e'(f), reg_idx_t'($urandom), reg_idx_t'($urandom),
                        $urandom), nop);
    end
    foreach (hints[i]) begin
      send_word(build_c(hints[i], REG_ZERO, reg_idx_t'($urandom), $urandom), nop);
    end
    check_results("legal");
  endtask

  task automatic test_illegal();
    parcel_t     ill[$];
    logic [31:0] r;
    r = $urandom;
    ill.push_back({3'b000, 8'b0, r[2:0], 2'b00});               // ADDI4SPN, imm 0
    ill.push_back(16'h6101);                                     // ADDI16SP, imm 0
    ill.push_back({3'b011, 1'b0, 5'd5, 5'd0, 2'b01});            // LUI, imm 0
    ill.push_back({3'b001, r[10:0], 2'b00});                     // Q0 reserved / FP / RV64
    ill.push_back({3'b011, r[13:3], 2'b00});
    ill.push_back({3'b100, r[15:5], 2'b00});
    ill.push_back({3'b101, r[20:10], 2'b00});
    ill.push_back({3'b111, r[25:15], 2'b00});
    ill.push_back({3'b100, 1'b1, 2'b11, r[2:0], 2'b00, r[5:3], 2'b01});  // SUBW
    ill.push_back({3'b100, 1'b1, 2'b11, r[2:0], 2'b01, r[5:3], 2'b01});  // ADDW
    ill.push_back({3'b000, 1'b1, r[8:4], r[13:9], 2'b10});              // SLLI shamt[5]
    ill.push_back({3'b100, 1'b1, 2'b00, r[2:0], r[7:3], 2'b01});        // SRLI shamt[5]
    ill.push_back({3'b010, r[0], 5'd0, r[5:1], 2'b10});                 // LWSP rd 0
    ill.push_back(16'h8002);                                             // JR rs1 0
    ill.push_back({3'b000, r[0], 5'd0, r[5:2], 1'b1, 2'b01});           // ADDI rd 0
    ill.push_back({3'b011, r[10:0], 2'b10});                            // LDSP
    ill.push_back({3'b111, r[20:10], 2'b10});                           // SDSP
    foreach (ill[i]) send_word(illegal_c(ill[i]), nop);
    check_results("illegal");
  endtask

  task automatic test_full32();
    instr_t w;
    w = $urandom | 32'h3;
    send_word(raw_parcel(w[15:0]), raw_parcel(w[31:16]));
    check_results("full32");
  endtask

  task automatic test_straddle();
    instr_t w;
    w = $urandom | 32'h3;
    send_word(random_c(), raw_parcel(w[15:0]));  // Word A
    send_word(raw_parcel(w[31:16]), random_c());  // Word B
    check_results("straddle");
  endtask

  task automatic test_stream();
    ref_parcel_t stream[$];
    instr_t      w;
    while (stream.size() < 80) begin
      if (stream.size() < 79 && $urandom % 3 == 0) begin
        w = $urandom | 32'h3;
        stream.push_back(raw_parcel(w[15:0]));
        stream.push_back(raw_parcel(w[31:16]));
      end else begin
        stream.push_back(random_c());
      end
    end
    for (int i = 0; i < stream.size(); i += 2) begin
      if ($urandom % 4 == 0) idle_cycles(1 + $urandom % 3);  // fetch_valid gap
      send_word(stream[i], stream[i + 1]);
    end
    check_results("stream");
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    void'($urandom(32'h911473fb));
    rst_n       = 1'b0;
    fetch_valid = 1'b0;
    fetch_word  = '0;
    held        = 1'b0;
    held_lo     = '0;
    cycles      = 0;
    nop         = build_c(CF_NOP, REG_ZERO, REG_ZERO, 32'h0);
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_reset_idle();
    test_legal();
    test_illegal();
    test_full32();
    test_straddle();
    test_stream();

    idle_cycles(5);
    check_eq("end extra results", 0, got_q.size());  // Nothing unexpected
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- hw/rvc_expand_top.sv
/*
 * RV32C expander top
 * Aligner, one expansion lane per parcel, then the issue packer.
 * Three register stages from fetch_valid to out_valid.
 */

module rvc_expand_top #(
  parameter  int NUM_LANES = 2,
  localparam int CNT_W     = $clog2(NUM_LANES + 1)
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    fetch_valid,
  input  rvc_isa_pkg::parcel_t [NUM_LANES-1:0]    fetch_word,
  output logic                                    out_valid,
  output rvc_pipe_pkg::lane_out_t [NUM_LANES-1:0] out_slots,
  output logic [CNT_W-1:0]                        out_count
);

  import rvc_pipe_pkg::*;

  logic                      slot_valid;
  logic                      lane_valid;  // slot_valid, lane stage delay
  lane_in_t  [NUM_LANES-1:0] lane_in;
  lane_out_t [NUM_LANES-1:0] lane_out;

  // Stage 1
  rvc_fetch_aligner #(.NUM_LANES(NUM_LANES)) u_aligner (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .fetch_word  (fetch_word),
    .slot_valid  (slot_valid),
    .lane_in     (lane_in)
  );

  // Stage 2, one lane per parcel
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    rvc_lane u_lane (
      .clk      (clk),
      .rst_n    (rst_n),
      .lane_in  (lane_in[i]),
      .lane_out (lane_out[i])
    );
  end

  // Word strobe follows the lanes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) lane_valid <= 1'b0;
    else        lane_valid <= slot_valid;
  end

  // Stage 3
  rvc_issue_packer #(.NUM_LANES(NUM_LANES)) u_packer (
    .clk        (clk),
    .rst_n      (rst_n),
    .lane_valid (lane_valid),
    .lane_out   (lane_out),
    .out_valid  (out_valid),
    .out_slots  (out_slots),
    .out_count  (out_count)
  );

endmodule

//--- hw/rvc_issue_packer.sv
/*
 * Issue packer
 * Compacts the valid lane results into the lowest output slots,
 * keeps lane order, zeroes the rest and counts them. Registered.
 */

module rvc_issue_packer #(
  parameter  int NUM_LANES = 2,
  localparam int CNT_W     = $clog2(NUM_LANES + 1)
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    lane_valid,
  input  rvc_pipe_pkg::lane_out_t [NUM_LANES-1:0] lane_out,
  output logic                                    out_valid,
  output rvc_pipe_pkg::lane_out_t [NUM_LANES-1:0] out_slots,
  output logic [CNT_W-1:0]                        out_count
);

  import rvc_pipe_pkg::*;

  lane_out_t [NUM_LANES-1:0] packed_d;
  logic [CNT_W-1:0]          count_d;

  // Left-pack in lane order
  always_comb begin
    packed_d = '0;
    count_d  = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (lane_out[i].valid) begin
        packed_d[count_d] = lane_out[i];
        count_d           = count_d + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_count <= '0;
    end else begin
      out_valid <= lane_valid;  // Pulses even for an empty word
      if (lane_valid) out_count <= count_d;
    end
  end

  always_ff @(posedge clk) begin
    if (lane_valid) out_slots <= packed_d;
  end

endmodule

//--- hw/rvc_lane.sv
/*
 * Expansion lane
 * Turns one aligner slot into a 32-bit RV32 instruction. Compressed
 * parcels are decoded by quadrant and funct3, reserved or unsupported
 * encodings are flagged illegal and replaced by a NOP. Assembled 32-bit
 * instructions pass straight through. Result is registered.
 */

module rvc_lane (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rvc_pipe_pkg::lane_in_t  lane_in,
  output rvc_pipe_pkg::lane_out_t lane_out
);

  import rvc_isa_pkg::*;
  import rvc_pipe_pkg::*;

  localparam logic [6:0] F7_ALT = 7'b0100000;  // SUB / SRAI

  // Compressed register field -> x8..x15
  function automatic reg_idx_t creg(input creg_idx_t r);
    return {2'b01, r};
  endfunction

  parcel_t c;
  assign c = lane_in.lo;

  // ==================================================
  // Field extraction
  // ==================================================
  logic [1:0] quad;
  logic [2:0] funct3;
  reg_idx_t   rd;      // Also rs1 in CR/CI forms
  reg_idx_t   rs2;
  reg_idx_t   rd_p;    // CIW/CL rd'
  reg_idx_t   rs1_p;   // Also rd' in CB ALU forms
  reg_idx_t   rs2_p;

  assign quad   = c[1:0];
  assign funct3 = c[15:13];
  assign rd     = c[11:7];
  assign rs2    = c[6:2];
  assign rd_p   = creg(c[4:2]);
  assign rs1_p  = creg(c[9:7]);
  assign rs2_p  = creg(c[4:2]);

  // Scrambled immediates, rebuilt in natural bit order
  logic [9:0]  imm_4spn;  // nzuimm[9:2], x4
  logic [6:0]  imm_lw;    // uimm[6:2]
  logic [7:0]  imm_lwsp;  // uimm[7:2]
  logic [7:0]  imm_swsp;
  logic [11:0] imm_6;     // Sign-extended imm[5:0], ADDI/LI/ANDI
  logic [11:0] imm_16sp;  // nzimm[9:4]
  logic [19:0] imm_lui;   // nzimm[17:12] sign-extended
  logic [5:0]  shamt;
  logic [20:0] imm_j;     // offset[11:1], sign-extended to 21 bits
  logic [12:0] imm_b;     // offset[8:1], sign-extended to 13 bits

  assign imm_4spn = {c[10:7], c[12:11], c[5], c[6], 2'b00};
  assign imm_lw   = {c[5], c[12:10], c[6], 2'b00};
  assign imm_lwsp = {c[3:2], c[12], c[6:4], 2'b00};
  assign imm_swsp = {c[8:7], c[12:9], 2'b00};
  assign imm_6    = {{7{c[12]}}, c[6:2]};
  assign imm_16sp = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000};
  assign imm_lui  = {{15{c[12]}}, c[6:2]};
  assign shamt    = {c[12], c[6:2]};  // Bit 5 reserved on RV32
  assign imm_j    = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11],
                     c[5:3], 1'b0};
  assign imm_b    = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};

  // ==================================================
  // Compressed decode
  // ==================================================
  instr_t exp_instr;
  logic   exp_illegal;

  always_comb begin
    exp_instr   = INSTR_NOP;  // Illegal forms leave the NOP
    exp_illegal = 1'b0;

    case (quad)
      // Quadrant 0: stack-relative add, word loads and stores
      2'b00: begin
        case (funct3)
          3'b000: begin  // C.ADDI4SPN
            if (imm_4spn == '0) exp_illegal = 1'b1;
            else exp_instr = {2'b00, imm_4spn, REG_SP, F3_ADD, rd_p, OPC_OP_IMM};
          end
          3'b010: exp_instr = {5'b0, imm_lw, rs1_p, F3_LW, rd_p, OPC_LOAD};  // C.LW
          3'b110: begin  // C.SW
            exp_instr = {5'b0, imm_lw[6:5], rs2_p, rs1_p, F3_SW, imm_lw[4:0], OPC_STORE};
          end
          default: exp_illegal = 1'b1;  // FP and RV64 forms
        endcase
      end

      // Quadrant 1: immediates, ALU, jumps, branches
      2'b01: begin
        case (funct3)
          3'b000: begin  // C.NOP / C.ADDI
            if (rd == REG_ZERO && imm_6 != '0) exp_illegal = 1'b1;
            else exp_instr = {imm_6, rd, F3_ADD, rd, OPC_OP_IMM};
          end
          3'b001: begin  // C.JAL
            exp_instr = {imm_j[20], imm_j[10:1], imm_j[11], imm_j[19:12], REG_RA, OPC_JAL};
          end
          3'b010: exp_instr = {imm_6, REG_ZERO, F3_ADD, rd, OPC_OP_IMM};  // C.LI, rd 0 hint
          3'b011: begin
            if (rd == REG_SP) begin  // C.ADDI16SP
              if (imm_16sp == '0) exp_illegal = 1'b1;
              else exp_instr = {imm_16sp, REG_SP, F3_ADD, REG_SP, OPC_OP_IMM};
            end else if (imm_6 != '0) begin  // C.LUI, rd 0 hint
              exp_instr = {imm_lui, rd, OPC_LUI};
            end else begin
              exp_illegal = 1'b1;  // Zero imm
            end
          end
          3'b100: begin
            case (c[11:10])
              2'b00: begin  // C.SRLI
                if (shamt[5]) exp_illegal = 1'b1;
                else exp_instr = {7'b0, shamt[4:0], rs1_p, F3_SR, rs1_p, OPC_OP_IMM};
              end
              2'b01: begin  // C.SRAI
                if (shamt[5]) exp_illegal = 1'b1;
                else exp_instr = {F7_ALT, shamt[4:0], rs1_p, F3_SR, rs1_p, OPC_OP_IMM};
              end
              2'b10: exp_instr = {imm_6, rs1_p, F3_AND, rs1_p, OPC_OP_IMM};  // C.ANDI
              default: begin
                case ({c[12], c[6:5]})  // Register-register group
                  3'b000: exp_instr = {F7_ALT, rs2_p, rs1_p, F3_ADD, rs1_p, OPC_OP};  // C.SUB
                  3'b001: exp_instr = {7'b0, rs2_p, rs1_p, F3_XOR, rs1_p, OPC_OP};
                  3'b010: exp_instr = {7'b0, rs2_p, rs1_p, F3_OR, rs1_p, OPC_OP};
                  3'b011: exp_instr = {7'b0, rs2_p, rs1_p, F3_AND, rs1_p, OPC_OP};
                  default: exp_illegal = 1'b1;  // SUBW/ADDW and reserved
                endcase
              end
            endcase
          end
          3'b101: begin  // C.J
            exp_instr = {imm_j[20], imm_j[10:1], imm_j[11], imm_j[19:12], REG_ZERO,
                         OPC_JAL};
          end
          3'b110: begin  // C.BEQZ
            exp_instr = {imm_b[12], imm_b[10:5], REG_ZERO, rs1_p, F3_BEQ, imm_b[4:1],
                         imm_b[11], OPC_BRANCH};
          end
          default: begin  // C.BNEZ
            exp_instr = {imm_b[12], imm_b[10:5], REG_ZERO, rs1_p, F3_BNE, imm_b[4:1],
                         imm_b[11], OPC_BRANCH};
          end
        endcase
      end

      // Quadrant 2: SP-relative, register moves, indirect jumps
      2'b10: begin
        case (funct3)
          3'b000: begin  // C.SLLI, rd 0 hint passes
            if (shamt[5]) exp_illegal = 1'b1;
            else exp_instr = {7'b0, shamt[4:0], rd, F3_SLL, rd, OPC_OP_IMM};
          end
          3'b010: begin  // C.LWSP
            if (rd == REG_ZERO) exp_illegal = 1'b1;
            else exp_instr = {4'b0, imm_lwsp, REG_SP, F3_LW, rd, OPC_LOAD};
          end
          3'b100: begin
            if (!c[12]) begin
              if (rs2 == REG_ZERO) begin  // C.JR
                if (rd == REG_ZERO) exp_illegal = 1'b1;
                else exp_instr = {12'b0, rd, F3_ADD, REG_ZERO, OPC_JALR};
              end else begin  // C.MV
                exp_instr = {7'b0, rs2, REG_ZERO, F3_ADD, rd, OPC_OP};
              end
            end else if (rs2 == REG_ZERO) begin
              if (rd == REG_ZERO) exp_instr = INSTR_EBREAK;  // C.EBREAK
              else exp_instr = {12'b0, rd, F3_ADD, REG_RA, OPC_JALR};  // C.JALR
            end else begin  // C.ADD
              exp_instr = {7'b0, rs2, rd, F3_ADD, rd, OPC_OP};
            end
          end
          3'b110: begin  // C.SWSP
            exp_instr = {4'b0, imm_swsp[7:5], rs2, REG_SP, F3_SW, imm_swsp[4:0], OPC_STORE};
          end
          default: exp_illegal = 1'b1;  // FP and LDSP/SDSP
        endcase
      end

      // Not compressed, never tagged C16 by the aligner
      default: exp_illegal = 1'b1;
    endcase
  end

  // ==================================================
  // Output register
  // ==================================================
  logic   valid_q;
  instr_t instr_q;
  logic   illegal_q;
  logic   is_c_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) valid_q <= 1'b0;
    else        valid_q <= (lane_in.kind != SLOT_EMPTY);
  end

  always_ff @(posedge clk) begin
    if (lane_in.kind == SLOT_FULL32) begin
      instr_q   <= {lane_in.hi, lane_in.lo};  // Pass through
      illegal_q <= 1'b0;
      is_c_q    <= 1'b0;
    end else begin
      instr_q   <= exp_instr;
      illegal_q <= exp_illegal;
      is_c_q    <= 1'b1;
    end
  end

  assign lane_out = '{valid: valid_q, instr: instr_q, illegal: illegal_q, is_c: is_c_q};

endmodule

//--- hw/rvc_fetch_aligner.sv
/*
 * Fetch aligner
 * Walks the parcels of each fetch word in address order, splits them
 * into compressed and 32-bit slots, and carries the lower half of a
 * 32-bit instruction that ends a word over to the next valid word.
 * Slots and their strobe come out one cycle after the fetch word.
 */

module rvc_fetch_aligner #(
  parameter int NUM_LANES = 2
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  fetch_valid,
  input  rvc_isa_pkg::parcel_t [NUM_LANES-1:0]  fetch_word,   // Parcel 0 at low address
  output logic                                  slot_valid,
  output rvc_pipe_pkg::lane_in_t [NUM_LANES-1:0] lane_in
);

  import rvc_isa_pkg::*;
  import rvc_pipe_pkg::*;

  lane_in_t [NUM_LANES-1:0] slots_d;  // Slot assignment for this word
  logic                     held_q;   // Lower half waiting for its upper half
  logic                     held_d;
  parcel_t                  held_lo_q;
  parcel_t                  held_lo_d;

  // ==================================================
  // Boundary scan
  // ==================================================
  always_comb begin
    logic skip;  // Parcel already consumed as an upper half
    slots_d   = '0;          // All SLOT_EMPTY
    held_d    = 1'b0;        // Only a fresh straddle sets it again
    held_lo_d = held_lo_q;
    skip      = 1'b0;

    // Finish the straddle from the previous word
    if (held_q) begin
      slots_d[0].kind = SLOT_FULL32;
      slots_d[0].lo   = held_lo_q;
      slots_d[0].hi   = fetch_word[0];
      skip            = 1'b1;
    end

    for (int i = 0; i < NUM_LANES; i++) begin
      if (skip) begin
        skip = 1'b0;  // Upper half, slot stays empty
      end else if (fetch_word[i][1:0] != QUAD_FULL) begin
        slots_d[i].kind = SLOT_C16;
        slots_d[i].lo   = fetch_word[i];
      end else if (i < NUM_LANES - 1) begin
        // Both halves in this word
        slots_d[i].kind = SLOT_FULL32;
        slots_d[i].lo   = fetch_word[i];
        slots_d[i].hi   = fetch_word[(i + 1) % NUM_LANES];
        skip            = 1'b1;
      end else begin
        held_d    = 1'b1;           // Last parcel starts a 32-bit instr
        held_lo_d = fetch_word[i];
      end
    end
  end

  // ==================================================
  // Registers
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_valid <= 1'b0;
      held_q     <= 1'b0;
      lane_in    <= '0;
    end else begin
      slot_valid <= fetch_valid;
      if (fetch_valid) begin
        held_q  <= held_d;
        lane_in <= slots_d;
      end else begin
        lane_in <= '0;  // Idle cycle, all slots empty; held state kept
      end
    end
  end

  // Held half is payload, qualified by held_q
  always_ff @(posedge clk) begin
    if (fetch_valid) held_lo_q <= held_lo_d;
  end

endmodule

//--- hw/rvc_pipe_pkg.sv
/*
 * Pipeline types for the compressed expander
 * Slot kinds from the aligner, per-lane input slots and lane results
 */

package rvc_pipe_pkg;

  // What a lane slot holds this cycle
  typedef enum logic [1:0] {
    SLOT_EMPTY  = 2'd0,  // Nothing, or second half of a pair
    SLOT_C16    = 2'd1,  // One compressed parcel in lo
    SLOT_FULL32 = 2'd2   // 32-bit instruction, {hi, lo}
  } slot_kind_e;

  // ==================================================
  // Aligner -> lane
  // ==================================================
  typedef struct packed {
    slot_kind_e          kind;
    rvc_isa_pkg::parcel_t lo;  // Lower address parcel
    rvc_isa_pkg::parcel_t hi;  // Upper half, SLOT_FULL32 only
  } lane_in_t;

  // ==================================================
  // Lane -> packer
  // ==================================================
  typedef struct packed {
    logic                valid;    // Slot produced an instruction
    rvc_isa_pkg::instr_t instr;    // Expanded or passed-through word
    logic                illegal;  // Reserved / unsupported C encoding
    logic                is_c;     // Came from a 16-bit parcel
  } lane_out_t;

endpackage

//--- hw/rvc_isa_pkg.sv
/*
 * RV32 base ISA definitions for the compressed expander
 * Parcel and instruction types, register indices, major opcodes,
 * funct3 codes and a few canned instructions
 */

package rvc_isa_pkg;

  // ==================================================
  // Types
  // ==================================================
  typedef logic [15:0] parcel_t;    // One 16-bit fetch parcel
  typedef logic [31:0] instr_t;     // Full base instruction
  typedef logic [4:0]  reg_idx_t;   // x0..x31
  typedef logic [2:0]  creg_idx_t;  // x8..x15 in compressed forms

  // ==================================================
  // Major opcodes (bits [6:0])
  // ==================================================
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // ==================================================
  // funct3 codes
  // ==================================================
  // ALU group
  localparam logic [2:0] F3_ADD = 3'b000;  // ADD/SUB/ADDI/JALR
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SR  = 3'b101;  // SRL and SRA
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // Branches
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // Word loads and stores
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_SW  = 3'b010;

  // Fixed registers
  localparam reg_idx_t REG_ZERO = 5'd0;
  localparam reg_idx_t REG_RA   = 5'd1;  // Link register
  localparam reg_idx_t REG_SP   = 5'd2;  // Stack pointer

  // Canned encodings
  localparam instr_t INSTR_NOP    = 32'h0000_0013;  // ADDI x0, x0, 0
  localparam instr_t INSTR_EBREAK = 32'h0010_0073;

  // Low bits of a parcel that starts a 32-bit instruction
  localparam logic [1:0] QUAD_FULL = 2'b11;

endpackage
